// ==== include/axi_params.svh ====
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// Channel field widths
`define AXI_ID_BITS    4
`define AXI_ADDR_BITS  32
`define AXI_DATA_BITS  32
`define AXI_STRB_BITS  4
`define AXI_LEN_BITS   8
`define AXI_SIZE_BITS  3

// Encoded field values
`define AXI_BURST_INC  2'b01
`define AXI_RESP_OKAY  2'b00
`define AXI_SIZE_WORD  3'b010

// On-chip SRAM geometry
`define SRAM_WORDS       256
`define SRAM_INDEX_BITS  8

`endif

// ==== verilog/axi_pkg.sv ====
`include "axi_params.svh"

package axi_pkg;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_LEN_BITS-1:0]  len;
    logic [`AXI_SIZE_BITS-1:0] size;
    logic [1:0]                burst;
  } axi_aw_t;

  typedef struct packed {
    logic [`AXI_DATA_BITS-1:0] data;
    logic [`AXI_STRB_BITS-1:0] strb;
    logic                      last;
  } axi_w_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0] id;
    logic [1:0]              resp;
  } axi_b_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_ADDR_BITS-1:0] addr;
    logic [`AXI_LEN_BITS-1:0]  len;
    logic [`AXI_SIZE_BITS-1:0] size;
    logic [1:0]                burst;
  } axi_ar_t;

  typedef struct packed {
    logic [`AXI_ID_BITS-1:0]   id;
    logic [`AXI_DATA_BITS-1:0] data;
    logic [1:0]                resp;
    logic                      last;
  } axi_r_t;

  // Master sequencing, one access at a time
  typedef enum logic [2:0] {
    st_idle, st_ar, st_r, st_aw, st_w, st_b
  } master_state_t;

  typedef enum logic [2:0] {
    sl_idle, sl_wait_w, sl_wait_aw, sl_bresp, sl_rresp
  } slave_state_t;

endpackage

// ==== verilog/axi_master.sv ====
`include "axi_params.svh"

module axi_master #(
  parameter logic [`AXI_ID_BITS-1:0] master_id = '0
) (
  input  logic                      clk,
  input  logic                      rstn,
  // CPU side
  input  logic                      access_request,
  input  logic                      write,
  input  logic [`AXI_STRB_BITS-1:0] wstrb,
  input  logic [`AXI_DATA_BITS-1:0] wdata,
  input  logic [`AXI_ADDR_BITS-1:0] addr,
  output logic [`AXI_DATA_BITS-1:0] data_out,
  output logic                      stall,
  // AXI side
  output axi_pkg::axi_aw_t          aw,
  output logic                      awvalid,
  input  logic                      awready,
  output axi_pkg::axi_w_t           w,
  output logic                      wvalid,
  input  logic                      wready,
  input  axi_pkg::axi_b_t           b,
  input  logic                      bvalid,
  output logic                      bready,
  output axi_pkg::axi_ar_t          ar,
  output logic                      arvalid,
  input  logic                      arready,
  input  axi_pkg::axi_r_t           r,
  input  logic                      rvalid,
  output logic                      rready
);

  axi_pkg::master_state_t state, next_state;

  logic [`AXI_ADDR_BITS-1:0] addr_r;
  logic [`AXI_DATA_BITS-1:0] wdata_r;
  logic [`AXI_STRB_BITS-1:0] wstrb_r;
  logic [`AXI_DATA_BITS-1:0] rdata_r;
  logic                      aw_hs, w_hs, b_hs, ar_hs, r_hs;

  // Valid and ready follow the state only
  assign awvalid = (state == axi_pkg::st_aw);
  // Data goes out together with the accepted address
  assign wvalid  = (state == axi_pkg::st_w) | ((state == axi_pkg::st_aw) & awready);
  assign bready  = (state == axi_pkg::st_b);
  assign arvalid = (state == axi_pkg::st_ar);
  assign rready  = (state == axi_pkg::st_r);
  assign stall   = (state != axi_pkg::st_idle);

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign b_hs  = bvalid & bready;
  assign ar_hs = arvalid & arready;
  assign r_hs  = rvalid & rready;

  // Read data bypass in the handshake cycle
  assign data_out = r_hs ? r.data : rdata_r;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rdata_r <= '0;
    end else if (r_hs) begin
      rdata_r <= r.data;
    end
  end

  // Request capture on leaving idle
  always_ff @(posedge clk) begin
    if (state == axi_pkg::st_idle && access_request) begin
      addr_r  <= addr;
      wdata_r <= wdata;
      wstrb_r <= wstrb;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= axi_pkg::st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      axi_pkg::st_idle: begin
        if (access_request) begin
          next_state = write ? axi_pkg::st_aw : axi_pkg::st_ar;
        end
      end
      axi_pkg::st_ar: if (ar_hs) next_state = axi_pkg::st_r;
      axi_pkg::st_r:  if (r_hs) next_state = axi_pkg::st_idle;
      axi_pkg::st_aw: begin
        if (aw_hs) begin
          next_state = w_hs ? axi_pkg::st_b : axi_pkg::st_w;
        end
      end
      axi_pkg::st_w: if (w_hs) next_state = axi_pkg::st_b;
      axi_pkg::st_b: if (b_hs) next_state = axi_pkg::st_idle;
      default: next_state = axi_pkg::st_idle;
    endcase
  end

  // Single-beat word transfers only
  always_comb begin
    aw.id    = master_id;
    aw.addr  = addr_r;
    aw.len   = '0;
    aw.size  = `AXI_SIZE_WORD;
    aw.burst = `AXI_BURST_INC;

    w.data = wdata_r;
    w.strb = wstrb_r;
    w.last = 1'b1;

    ar.id    = master_id;
    ar.addr  = addr_r;
    ar.len   = '0;
    ar.size  = `AXI_SIZE_WORD;
    ar.burst = `AXI_BURST_INC;
  end

endmodule

// ==== verilog/axi_sram_slave.sv ====
`include "axi_params.svh"

module axi_sram_slave (
  input  logic             clk,
  input  logic             rstn,
  input  axi_pkg::axi_aw_t aw,
  input  logic             awvalid,
  output logic             awready,
  input  axi_pkg::axi_w_t  w,
  input  logic             wvalid,
  output logic             wready,
  output axi_pkg::axi_b_t  b,
  output logic             bvalid,
  input  logic             bready,
  input  axi_pkg::axi_ar_t ar,
  input  logic             arvalid,
  output logic             arready,
  output axi_pkg::axi_r_t  r,
  output logic             rvalid,
  input  logic             rready
);

  localparam int unsigned byte_offset_bits = $clog2(`AXI_STRB_BITS);

  axi_pkg::slave_state_t state, next_state;

  logic [`AXI_DATA_BITS-1:0] mem [`SRAM_WORDS];

  axi_pkg::axi_aw_t           aw_r, wr_aw;
  axi_pkg::axi_w_t            w_r, wr_w;
  logic [`AXI_ID_BITS-1:0]    bid_r;
  logic [`AXI_ID_BITS-1:0]    rid_r;
  logic [`AXI_DATA_BITS-1:0]  rdata_r;
  logic [`SRAM_INDEX_BITS-1:0] wr_index, rd_index;
  logic                       aw_hs, w_hs, ar_hs;
  logic                       have_aw, have_w, wr_commit;

  // Readies come from state; writes win over reads in idle
  assign awready = (state == axi_pkg::sl_idle) | (state == axi_pkg::sl_wait_aw);
  assign wready  = (state == axi_pkg::sl_idle) | (state == axi_pkg::sl_wait_w);
  assign arready = (state == axi_pkg::sl_idle) & ~awvalid & ~wvalid;
  assign bvalid  = (state == axi_pkg::sl_bresp);
  assign rvalid  = (state == axi_pkg::sl_rresp);

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;
  assign ar_hs = arvalid & arready;

  // Pick up whichever half arrived earlier
  assign wr_aw     = (state == axi_pkg::sl_wait_w) ? aw_r : aw;
  assign wr_w      = (state == axi_pkg::sl_wait_aw) ? w_r : w;
  assign have_aw   = aw_hs | (state == axi_pkg::sl_wait_w);
  assign have_w    = w_hs | (state == axi_pkg::sl_wait_aw);
  assign wr_commit = have_aw & have_w;

  // Addresses wrap on the memory depth
  assign wr_index = wr_aw.addr[byte_offset_bits +: `SRAM_INDEX_BITS];
  assign rd_index = ar.addr[byte_offset_bits +: `SRAM_INDEX_BITS];

  always_ff @(posedge clk) begin
    if (wr_commit) begin
      for (int i = 0; i < `AXI_STRB_BITS; i++) begin
        if (wr_w.strb[i]) begin
          mem[wr_index][8*i +: 8] <= wr_w.data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      aw_r <= aw;
    end
    if (w_hs) begin
      w_r <= w;
    end
    if (wr_commit) begin
      bid_r <= wr_aw.id;
    end
    if (ar_hs) begin
      rid_r   <= ar.id;
      rdata_r <= mem[rd_index];
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= axi_pkg::sl_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      axi_pkg::sl_idle: begin
        if (wr_commit) begin
          next_state = axi_pkg::sl_bresp;
        end else if (aw_hs) begin
          next_state = axi_pkg::sl_wait_w;
        end else if (w_hs) begin
          next_state = axi_pkg::sl_wait_aw;
        end else if (ar_hs) begin
          next_state = axi_pkg::sl_rresp;
        end
      end
      axi_pkg::sl_wait_w,
      axi_pkg::sl_wait_aw: if (wr_commit) next_state = axi_pkg::sl_bresp;
      axi_pkg::sl_bresp:   if (bready) next_state = axi_pkg::sl_idle;
      axi_pkg::sl_rresp:   if (rready) next_state = axi_pkg::sl_idle;
      default: next_state = axi_pkg::sl_idle;
    endcase
  end

  // Responses are always OKAY
  always_comb begin
    b.id   = bid_r;
    b.resp = `AXI_RESP_OKAY;

    r.id   = rid_r;
    r.data = rdata_r;
    r.resp = `AXI_RESP_OKAY;
    r.last = 1'b1;
  end

endmodule

// ==== verilog/axi_mem_subsystem.sv ====
`include "axi_params.svh"

module axi_mem_subsystem (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      access_request,
  input  logic                      write,
  input  logic [`AXI_STRB_BITS-1:0] wstrb,
  input  logic [`AXI_DATA_BITS-1:0] wdata,
  input  logic [`AXI_ADDR_BITS-1:0] addr,
  output logic [`AXI_DATA_BITS-1:0] data_out,
  output logic                      stall
);

  axi_pkg::axi_aw_t aw;
  axi_pkg::axi_w_t  w;
  axi_pkg::axi_b_t  b;
  axi_pkg::axi_ar_t ar;
  axi_pkg::axi_r_t  r;
  logic             awvalid, awready;
  logic             wvalid, wready;
  logic             bvalid, bready;
  logic             arvalid, arready;
  logic             rvalid, rready;

  axi_master #(
    .master_id(`AXI_ID_BITS'(1))
  ) u_master (
    .clk, .rstn,
    .access_request, .write, .wstrb, .wdata, .addr,
    .data_out, .stall,
    .aw, .awvalid, .awready,
    .w, .wvalid, .wready,
    .b, .bvalid, .bready,
    .ar, .arvalid, .arready,
    .r, .rvalid, .rready
  );

  axi_sram_slave u_sram (
    .clk, .rstn,
    .aw, .awvalid, .awready,
    .w, .wvalid, .wready,
    .b, .bvalid, .bready,
    .ar, .arvalid, .arready,
    .r, .rvalid, .rready
  );

endmodule

// ==== verification/tb_axi_mem_subsystem.sv ====
`include "axi_params.svh"

module tb_axi_mem_subsystem;

  localparam int clk_period = 100;
  // About 270 accesses at four cycles each, well under the limit
  localparam int timeout_cycles = 3000;
  localparam int random_ops = 250;
  localparam int window_words = 16;
  localparam int word_bytes = `AXI_DATA_BITS / 8;

  logic                      clk;
  logic                      rstn;
  logic                      access_request;
  logic                      write;
  logic [`AXI_STRB_BITS-1:0] wstrb;
  logic [`AXI_DATA_BITS-1:0] wdata;
  logic [`AXI_ADDR_BITS-1:0] addr;
  logic [`AXI_DATA_BITS-1:0] data_out;
  logic                      stall;

  // Shadow memory and expected data_out per access
  logic [`AXI_DATA_BITS-1:0] shadow [`SRAM_WORDS];
  bit                        written [`SRAM_WORDS];
  logic [`AXI_DATA_BITS-1:0] last_read;
  logic [`AXI_DATA_BITS-1:0] exp_q [$];
  logic [`AXI_ADDR_BITS-1:0] addr_q [$];
  int                        value_errors = 0;
  int                        stall_errors = 0;
  int                        other_errors = 0;

  axi_mem_subsystem i_dut (
    .clk, .rstn,
    .access_request, .write, .wstrb, .wdata, .addr,
    .data_out, .stall
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [`AXI_DATA_BITS-1:0] merge_word(
    input logic [`AXI_DATA_BITS-1:0] old_word,
    input logic [`AXI_DATA_BITS-1:0] new_data,
    input logic [`AXI_STRB_BITS-1:0] strb
  );
    logic [`AXI_DATA_BITS-1:0] mask;
    for (int i = 0; i < `AXI_STRB_BITS; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return (old_word & ~mask) | (new_data & mask);
  endfunction

  function automatic int word_index(input logic [`AXI_ADDR_BITS-1:0] a);
    return int'((a / word_bytes) % `SRAM_WORDS);
  endfunction

  task automatic run_access(
    input logic                      is_write,
    input logic [`AXI_ADDR_BITS-1:0] a,
    input logic [`AXI_DATA_BITS-1:0] data,
    input logic [`AXI_STRB_BITS-1:0] strb
  );
    int idx;
    int stall_cycles;
    idx = word_index(a);
    if (is_write) begin
      shadow[idx] = merge_word(shadow[idx], data, strb);
      written[idx] = 1'b1;
    end else begin
      last_read = shadow[idx];
    end
    // Writes must leave data_out at the last read value
    exp_q.push_back(last_read);
    addr_q.push_back(a);
    @(posedge clk);
    access_request <= 1'b1;
    write <= is_write;
    addr <= a;
    wdata <= data;
    wstrb <= strb;
    @(posedge clk);
    access_request <= 1'b0;
    stall_cycles = 0;
    @(negedge clk);
    while (stall) begin
      stall_cycles++;
      // Read data shows through in the response cycle
      if (stall_cycles == 2) begin
        assert (data_out === last_read) else begin
          value_errors++;
          $display("MISMATCH at %0t: addr 0x%08h bypass expected 0x%08h actual 0x%08h",
                   $time, a, last_read, data_out);
        end
      end
      @(negedge clk);
    end
    assert (stall_cycles == 2) else begin
      stall_errors++;
      $display("MISMATCH at %0t: addr 0x%08h stall high for %0d cycles, expected 2",
               $time, a, stall_cycles);
    end
  endtask

  // Checks data_out each time an access completes
  initial begin
    logic                      stall_seen;
    logic [`AXI_DATA_BITS-1:0] expected;
    logic [`AXI_ADDR_BITS-1:0] a;
    stall_seen = 1'b0;
    forever begin
      @(negedge clk);
      if (stall_seen && !stall) begin
        assert (exp_q.size() != 0) else begin
          other_errors++;
          $display("Error at %0t: stall fell with no access outstanding", $time);
        end
        if (exp_q.size() != 0) begin
          expected = exp_q.pop_front();
          a = addr_q.pop_front();
          assert (data_out === expected) else begin
            value_errors++;
            $display("MISMATCH at %0t: addr 0x%08h expected 0x%08h actual 0x%08h",
                     $time, a, expected, data_out);
          end
        end
      end
      stall_seen = stall;
    end
  end

  initial begin
    int cycles;
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Error: run did not finish within %0d cycles", timeout_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int                        word;
    logic                      is_write;
    logic [`AXI_ADDR_BITS-1:0] a;
    logic [`AXI_STRB_BITS-1:0] strb;
    void'($urandom(44319));
    rstn = 1'b0;
    access_request = 1'b0;
    write = 1'b0;
    wstrb = '0;
    wdata = '0;
    addr = '0;
    last_read = '0;
    for (int i = 0; i < `SRAM_WORDS; i++) begin
      shadow[i] = '0;
      written[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    assert (stall === 1'b0 && data_out === '0) else begin
      value_errors++;
      $display("MISMATCH at %0t: after reset stall %b data_out 0x%08h", $time, stall, data_out);
    end

    run_access(1'b1, 32'h0000_0040, 32'hdead_beef, 4'hf);
    run_access(1'b0, 32'h0000_0040, '0, '0);

    // Byte and half-word strobes on one word
    run_access(1'b1, 32'h0000_0080, 32'h1122_3344, 4'hf);
    run_access(1'b1, 32'h0000_0080, 32'haabb_ccdd, 4'b0001);
    run_access(1'b0, 32'h0000_0080, '0, '0);
    run_access(1'b1, 32'h0000_0080, 32'haabb_ccdd, 4'b0100);
    run_access(1'b0, 32'h0000_0080, '0, '0);
    run_access(1'b1, 32'h0000_0080, 32'h5566_7788, 4'b0011);
    run_access(1'b0, 32'h0000_0080, '0, '0);
    run_access(1'b1, 32'h0000_0080, 32'h99ee_ff00, 4'b1100);
    run_access(1'b0, 32'h0000_0080, '0, '0);

    // One memory size above aliases the lower word
    run_access(1'b1, 32'h0000_0010, 32'h0101_0101, 4'hf);
    run_access(1'b1, 32'h0000_0010 + `SRAM_WORDS * word_bytes, 32'hcafe_f00d, 4'hf);
    run_access(1'b0, 32'h0000_0010, '0, '0);

    run_access(1'b0, 32'h0000_0040, '0, '0);
    run_access(1'b1, 32'h0000_0044, 32'h0bad_cafe, 4'hf);
    run_access(1'b1, 32'h0000_0048, 32'h1234_5678, 4'b0110);
    repeat (5) begin
      @(negedge clk);
      assert (data_out === last_read) else begin
        value_errors++;
        $display("MISMATCH at %0t: idle data_out expected 0x%08h actual 0x%08h",
                 $time, last_read, data_out);
      end
    end

    for (int n = 0; n < random_ops; n++) begin
      word = int'($urandom_range(0, window_words - 1));
      a = 32'h0000_0200 + 32'(word * word_bytes) + 32'($urandom_range(0, word_bytes - 1));
      is_write = ($urandom_range(0, 1) == 1);
      strb = 4'($urandom_range(0, 15));
      // First touch of a word is a full write
      if (!written[word_index(a)]) begin
        is_write = 1'b1;
        strb = 4'hf;
      end
      run_access(is_write, a, $urandom, strb);
    end

    repeat (4) @(negedge clk);
    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("Error: %0d accesses never completed", exp_q.size());
    end
    $display("Errors: %0d value, %0d stall timing, %0d other",
             value_errors, stall_errors, other_errors);
    if (value_errors + stall_errors + other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
verilog/axi_pkg.sv
verilog/axi_master.sv
verilog/axi_sram_slave.sv
verilog/axi_mem_subsystem.sv
verification/tb_axi_mem_subsystem.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_axi_mem_subsystem
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F -x '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
